/* hdl/video_pkg.sv */
// raster sizes here are small test values, not a real monitor mode; all modules assume them
package video_pkg;

    // raster geometry in pixels and lines
    localparam int H_ACTIVE = 16;
    localparam int H_TOTAL  = 24;
    localparam int V_ACTIVE = 8;
    localparam int V_TOTAL  = 12;

    // bitmap layout in vram
    localparam int MAP_W_WORDS  = 8;
    localparam int MAP_H        = 16;
    // pixel 0 sits in the low nibble of a word
    localparam int PXL_PER_WORD = 4;

    // cpu register word addresses
    localparam logic [4:0] REG_CTRL    = 5'd0;
    localparam logic [4:0] REG_BASE    = 5'd1;
    localparam logic [4:0] REG_HSCROLL = 5'd2;
    localparam logic [4:0] REG_VSCROLL = 5'd3;
    localparam logic [4:0] REG_STATUS  = 5'd4;
    // 16 to 31 map onto the palette
    localparam logic [4:0] PAL_BASE    = 5'd16;

    // rgb 4:4:4, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pal_entry_t;

endpackage

/* hdl/video_regs_if.sv */
// register values are held by video_mmr alone; the fetcher may only raise underrun_set
`timescale 1ns/1ps

interface video_regs_if import video_pkg::*; ();
    logic [15:0] vram_base;
    logic [15:0] hscroll;
    logic [15:0] vscroll;
    logic        layer_en;
    logic        underrun_set;
    logic        pal_we;
    logic [3:0]  pal_addr;
    pal_entry_t  pal_data;

    modport mmr_mp (
        output vram_base, hscroll, vscroll, layer_en,
        output pal_we, pal_addr, pal_data,
        input  underrun_set
    );
    modport fetch_mp (input vram_base, hscroll, vscroll, layer_en, output underrun_set);
    modport mix_mp (input layer_en, pal_we, pal_addr, pal_data);

endinterface

/* hdl/video_timing.sv */
// counters only move on pxl_cen; line_start comes one clk after the hdump wrap edge
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE,
    parameter int H_TOTAL  = video_pkg::H_TOTAL,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE,
    parameter int V_TOTAL  = video_pkg::V_TOTAL
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output logic [8:0] vrender,
    output logic       hb,
    output logic       vb,
    output logic       hs,
    output logic       vs,
    output logic       line_start
);

    // sync pulse placement inside the blanking intervals
    localparam int HS_START = H_ACTIVE + 2;
    localparam int HS_END   = H_ACTIVE + 3;
    localparam int VS_LINE  = V_ACTIVE + 1;

    logic h_last;
    logic v_last;

    assign h_last = hdump == 9'(H_TOTAL - 1);
    assign v_last = vdump == 9'(V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdump      <= '0;
            vdump      <= '0;
            line_start <= 1'b0;
        end else begin
            line_start <= pxl_cen && h_last;
            if (pxl_cen) begin
                hdump <= h_last ? 9'd0 : hdump + 9'd1;
                if (h_last) begin
                    vdump <= v_last ? 9'd0 : vdump + 9'd1;
                end
            end
        end
    end

    // the line being fetched is always one ahead of the one shown
    assign vrender = v_last ? 9'd0 : vdump + 9'd1;

    assign hb = hdump >= 9'(H_ACTIVE);
    assign vb = vdump >= 9'(V_ACTIVE);
    assign hs = (hdump >= 9'(HS_START)) && (hdump <= 9'(HS_END));
    assign vs = vdump == 9'(VS_LINE);

    hdump_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        hdump < 9'(H_TOTAL));

endmodule

/* hdl/video_mmr.sv */
// palette words are write-only and read back as 0; a set of the underrun flag beats a clear
`timescale 1ns/1ps

module video_mmr import video_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cpu_cs,
    input  logic        cpu_we,
    input  logic [4:0]  cpu_addr,
    input  logic [15:0] cpu_din,
    output logic [15:0] cpu_dout,
    video_regs_if.mmr_mp regs
);

    logic [15:0] ctrl;
    logic [15:0] base;
    logic [15:0] hscroll;
    logic [15:0] vscroll;
    logic        underrun;
    logic        wr;
    logic [15:0] rd_mux;

    assign wr = cpu_cs && cpu_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl        <= '0;
            base        <= '0;
            hscroll     <= '0;
            vscroll     <= '0;
            underrun    <= 1'b0;
            regs.pal_we <= 1'b0;
        end else begin
            if (wr && cpu_addr == REG_CTRL)    ctrl    <= cpu_din;
            if (wr && cpu_addr == REG_BASE)    base    <= cpu_din;
            if (wr && cpu_addr == REG_HSCROLL) hscroll <= cpu_din;
            if (wr && cpu_addr == REG_VSCROLL) vscroll <= cpu_din;
            // write 1 to clear
            underrun <= (underrun && !(wr && cpu_addr == REG_STATUS && cpu_din[0]))
                        || regs.underrun_set;
            regs.pal_we <= wr && cpu_addr >= PAL_BASE;
        end
    end

    always_ff @(posedge clk) begin
        regs.pal_addr <= cpu_addr[3:0];
        regs.pal_data <= pal_entry_t'(cpu_din[11:0]);
    end

    always_comb begin
        case (cpu_addr)
            REG_CTRL:    rd_mux = ctrl;
            REG_BASE:    rd_mux = base;
            REG_HSCROLL: rd_mux = hscroll;
            REG_VSCROLL: rd_mux = vscroll;
            REG_STATUS:  rd_mux = {15'd0, underrun};
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cpu_cs && !cpu_we) cpu_dout <= rd_mux;
    end

    assign regs.vram_base = base;
    assign regs.hscroll   = hscroll;
    assign regs.vscroll   = vscroll;
    assign regs.layer_en  = ctrl[0];

    pal_we_from_cpu: assert property (@(posedge clk) disable iff (!rst_n)
        regs.pal_we |-> $past(cpu_cs && cpu_we && cpu_addr >= PAL_BASE));

endmodule

/* hdl/layer_fetch.sv */
// one vram word at a time; words still missing at the swap show as pixel 0
`timescale 1ns/1ps

module layer_fetch import video_pkg::*; #(
    parameter int H_ACTIVE    = video_pkg::H_ACTIVE,
    parameter int MAP_W_WORDS = video_pkg::MAP_W_WORDS
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        line_start,
    input  logic [8:0]  vrender,
    input  logic [8:0]  hdump,
    video_regs_if.fetch_mp regs,
    output logic        vram_req,
    output logic [15:0] vram_addr,
    input  logic        vram_ack,
    input  logic [15:0] vram_data,
    output logic [3:0]  pxl
);

    localparam int WORDS = H_ACTIVE / PXL_PER_WORD;
    localparam int WIW   = $clog2(WORDS);

    logic [15:0]        lbuf [2][WORDS];
    logic [1:0][WORDS-1:0] vld;
    logic               bank;
    logic [WIW:0]       widx;
    logic               stale;
    logic [15:0]        row_base;
    logic [15:0]        hscr;
    logic [WIW-1:0]     wsel;
    logic [1:0]         nsel;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vram_req          <= 1'b0;
            widx              <= (WIW + 1)'(WORDS);
            stale             <= 1'b0;
            bank              <= 1'b0;
            vld               <= '0;
            regs.underrun_set <= 1'b0;
        end else begin
            regs.underrun_set <= 1'b0;
            if (vram_req && vram_ack) begin
                vram_req <= 1'b0;
                stale    <= 1'b0;
                // data of a request left over from the previous line is dropped
                if (!stale && !line_start) begin
                    vld[~bank][widx[WIW-1:0]] <= 1'b1;
                    widx <= widx + 1'b1;
                end
            end else if (!vram_req && !vram_ack && !line_start
                         && widx != (WIW + 1)'(WORDS)) begin
                vram_req <= 1'b1;
            end
            if (line_start) begin
                bank              <= ~bank;
                vld[bank]         <= '0;
                widx              <= '0;
                stale             <= vram_req && !vram_ack;
                regs.underrun_set <= widx != (WIW + 1)'(WORDS);
            end
        end
    end

    // payload side of the fetch
    always_ff @(posedge clk) begin
        if (line_start) begin
            row_base <= regs.vram_base
                        + 16'(((vrender + regs.vscroll) % MAP_H) * MAP_W_WORDS);
            hscr     <= regs.hscroll;
        end
        if (!vram_req && !vram_ack && !line_start) begin
            vram_addr <= row_base + 16'((hscr + widx) % MAP_W_WORDS);
        end
        if (vram_req && vram_ack && !stale && !line_start) begin
            lbuf[~bank][widx[WIW-1:0]] <= vram_data;
        end
    end

    // front bank read, follows hdump without a register
    assign wsel = hdump[WIW+1:2];
    assign nsel = hdump[1:0];

    always_comb begin
        if (hdump < 9'(H_ACTIVE) && vld[bank][wsel]) begin
            pxl = lbuf[bank][wsel][{nsel, 2'b00} +: 4];
        end else begin
            pxl = '0;
        end
    end

    req_held_to_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(vram_req) |-> $past(vram_ack));
    req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(vram_req) |-> !$past(vram_ack));

endmodule

/* hdl/colmix.sv */
// palette has no reset, so entries must be written before the layer shows sensible colours
`timescale 1ns/1ps

module colmix import video_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic       hb,
    input  logic       vb,
    input  logic [3:0] pxl,
    video_regs_if.mix_mp regs,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    output logic       hb_dly,
    output logic       vb_dly
);

    pal_entry_t pal [16];
    pal_entry_t entry;
    logic [3:0] idx;

    always_ff @(posedge clk) begin
        if (regs.pal_we) pal[regs.pal_addr] <= regs.pal_data;
    end

    // disabled layer falls back to the backdrop colour
    assign idx   = regs.layer_en ? pxl : 4'd0;
    assign entry = pal[idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red    <= '0;
            green  <= '0;
            blue   <= '0;
            hb_dly <= 1'b1;
            vb_dly <= 1'b1;
        end else if (pxl_cen) begin
            hb_dly <= hb;
            vb_dly <= vb;
            if (hb || vb) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                // nibble repeat spreads 0..15 over the full 0..255 range
                red   <= {entry.r, entry.r};
                green <= {entry.g, entry.g};
                blue  <= {entry.b, entry.b};
            end
        end
    end

endmodule

/* hdl/video_top.sv */
// rgb lags hdump and vdump by one pxl_cen tick; vram must follow the four-phase req/ack rule
`timescale 1ns/1ps

module video_top #(
    parameter int H_ACTIVE    = video_pkg::H_ACTIVE,
    parameter int H_TOTAL     = video_pkg::H_TOTAL,
    parameter int V_ACTIVE    = video_pkg::V_ACTIVE,
    parameter int V_TOTAL     = video_pkg::V_TOTAL,
    parameter int MAP_W_WORDS = video_pkg::MAP_W_WORDS
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    // cpu bus
    input  logic        cpu_cs,
    input  logic        cpu_we,
    input  logic [4:0]  cpu_addr,
    input  logic [15:0] cpu_din,
    output logic [15:0] cpu_dout,
    // vram
    output logic        vram_req,
    output logic [15:0] vram_addr,
    input  logic        vram_ack,
    input  logic [15:0] vram_data,
    // video
    output logic [8:0]  hdump,
    output logic [8:0]  vdump,
    output logic        hs,
    output logic        vs,
    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue,
    output logic        hb_dly,
    output logic        vb_dly
);

    logic [8:0] vrender;
    logic       hb;
    logic       vb;
    logic       line_start;
    logic [3:0] pxl;

    video_regs_if regs ();

    video_timing #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) u_timing (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .pxl_cen    ( pxl_cen    ),
        .hdump      ( hdump      ),
        .vdump      ( vdump      ),
        .vrender    ( vrender    ),
        .hb         ( hb         ),
        .vb         ( vb         ),
        .hs         ( hs         ),
        .vs         ( vs         ),
        .line_start ( line_start )
    );

    video_mmr u_mmr (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cpu_cs   ( cpu_cs   ),
        .cpu_we   ( cpu_we   ),
        .cpu_addr ( cpu_addr ),
        .cpu_din  ( cpu_din  ),
        .cpu_dout ( cpu_dout ),
        .regs     ( regs     )
    );

    layer_fetch #(
        .H_ACTIVE    ( H_ACTIVE    ),
        .MAP_W_WORDS ( MAP_W_WORDS )
    ) u_fetch (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .line_start ( line_start ),
        .vrender    ( vrender    ),
        .hdump      ( hdump      ),
        .regs       ( regs       ),
        .vram_req   ( vram_req   ),
        .vram_addr  ( vram_addr  ),
        .vram_ack   ( vram_ack   ),
        .vram_data  ( vram_data  ),
        .pxl        ( pxl        )
    );

    colmix u_colmix (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .pxl_cen ( pxl_cen ),
        .hb      ( hb      ),
        .vb      ( vb      ),
        .pxl     ( pxl     ),
        .regs    ( regs    ),
        .red     ( red     ),
        .green   ( green   ),
        .blue    ( blue    ),
        .hb_dly  ( hb_dly  ),
        .vb_dly  ( vb_dly  )
    );

endmodule

/* tests/video_tb_model.svh */
// expected video values; the including module must declare vram_m, pal_m and the *_m registers
`ifndef VIDEO_TB_MODEL_SVH
`define VIDEO_TB_MODEL_SVH

// vram word behind word w of visible line v, with scroll wrap and 16-bit base wrap
function automatic logic [15:0] vram_word_addr(input int v, input int w);
    int row;
    int col;
    row = (v + int'(vscroll_m)) % MAP_H;
    col = (int'(hscroll_m) + w) % MAP_W_WORDS;
    return base_m + 16'(row * MAP_W_WORDS + col);
endfunction

// {hb_dly, vb_dly, red, green, blue} one pxl_cen tick after the counters were at (h, v)
function automatic logic [25:0] expected_video(input int h, input int v);
    logic [15:0] word;
    logic [3:0]  idx;
    pal_entry_t  c;
    logic        hblank;
    logic        vblank;
    hblank = h >= H_ACTIVE;
    vblank = v >= V_ACTIVE;
    if (hblank || vblank) begin
        return {hblank, vblank, 24'd0};
    end
    word = vram_m[vram_word_addr(v, h / PXL_PER_WORD)];
    // backdrop entry when the layer is off
    idx  = ctrl_m[0] ? word[4 * (h % PXL_PER_WORD) +: 4] : 4'd0;
    c    = pal_m[idx];
    return {2'b00, c.r, c.r, c.g, c.g, c.b, c.b};
endfunction

`endif

/* tests/video_tb.sv */
// checks video_top frame by frame against a 64k-word random vram model; needs --timing to run
`timescale 1ns/1ps

module video_tb import video_pkg::*; ();

    localparam int FRAME_TICKS = H_TOTAL * V_TOTAL;
    // in clk cycles, two full frames
    localparam int WAIT_LIMIT  = 4 * FRAME_TICKS;
    localparam int ROWS        = 6;
    // sync positions of the raster
    localparam int HS_FIRST    = 18;
    localparam int HS_LAST     = 19;
    localparam int VS_LINE     = 9;

    logic        clk;
    logic        rst_n;
    logic        pxl_cen;
    logic        cpu_cs;
    logic        cpu_we;
    logic [4:0]  cpu_addr;
    logic [15:0] cpu_din;
    logic [15:0] cpu_dout;
    logic        vram_req;
    logic [15:0] vram_addr;
    logic        vram_ack;
    logic [15:0] vram_data;
    logic [8:0]  hdump;
    logic [8:0]  vdump;
    logic        hs;
    logic        vs;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic        hb_dly;
    logic        vb_dly;

    // model copies of memory and registers
    logic [15:0] vram_m [65536];
    pal_entry_t  pal_m [16];
    logic [15:0] ctrl_m;
    logic [15:0] base_m;
    logic [15:0] hscroll_m;
    logic [15:0] vscroll_m;
    int          vram_mode = 0;
    int          seed = 43015;
    int          errors = 0;
    int          checks = 0;
    bit          hung = 1'b0;

    // ctrl, base, hscroll, vscroll, vram delay mode, frames
    // mode 0 acks at once, 1 after 0 to 3 clk, 2 holds ack off for 40 clk
    int stim [ROWS][6] = '{
        '{1, 'h0000, 0,  0,  0, 1},
        '{1, 'h0100, 3,  5,  1, 2},
        '{1, 'hfff0, 11, 19, 1, 2},
        '{0, 'h0040, 1,  2,  1, 1},
        '{1, 'h0200, 0,  0,  2, 1},
        '{1, 'h0200, 6,  9,  1, 2}
    };

    `include "video_tb_model.svh"

    video_top dut (.*);

    initial begin
        clk     = 1'b0;
        pxl_cen = 1'b0;
        forever begin
            #2 clk = 1'b1;
            #2 clk = 1'b0;
            // pixel enable on every second clk
            pxl_cen <= ~pxl_cen;
        end
    end

    // vram answers each request after a delay set by the current row
    initial begin
        int delay;
        int guard;
        vram_ack  = 1'b0;
        vram_data = '0;
        while (!hung) begin
            @(negedge clk);
            if (vram_req && !vram_ack) begin
                case (vram_mode)
                    1:       delay = int'({$random(seed)} % 4);
                    2:       delay = 40;
                    default: delay = 0;
                endcase
                repeat (delay) @(negedge clk);
                vram_data = vram_m[vram_addr];
                vram_ack  = 1'b1;
                guard = 0;
                while (vram_req && guard < WAIT_LIMIT) begin
                    guard++;
                    @(negedge clk);
                end
                if (vram_req) begin
                    $display("timeout: vram_req still high long after vram_ack");
                    hung = 1'b1;
                end
                vram_ack = 1'b0;
            end
        end
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [15:0] data);
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_we   = 1'b1;
        cpu_addr = addr;
        cpu_din  = data;
        @(negedge clk);
        cpu_cs = 1'b0;
        cpu_we = 1'b0;
    endtask

    task automatic read_expect(input logic [4:0] addr, input logic [15:0] exp, input string what);
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_we   = 1'b0;
        cpu_addr = addr;
        @(negedge clk);
        cpu_cs = 1'b0;
        compare(what, {16'd0, cpu_dout}, {16'd0, exp});
    endtask

    task automatic await_vblank();
        int guard;
        guard = 0;
        @(negedge clk);
        while ((vdump != 9'(V_ACTIVE) || hdump != 9'd0) && guard < WAIT_LIMIT && !hung) begin
            guard++;
            @(negedge clk);
        end
        if (vdump != 9'(V_ACTIVE) || hdump != 9'd0) begin
            $display("timeout: vertical blanking never started");
            hung = 1'b1;
        end
    endtask

    // walks one frame from its first pixel and checks counters and syncs on every tick
    // pixels are compared only when check_en
    task automatic scan_frame(input logic check_en);
        int   guard;
        int   ticks;
        int   h;
        int   v;
        int   h_next;
        int   v_next;
        logic hs_exp;
        logic vs_exp;
        guard = 0;
        @(negedge clk);
        while ((hdump != 9'd0 || vdump != 9'd0) && guard < WAIT_LIMIT && !hung) begin
            guard++;
            @(negedge clk);
        end
        if (hdump != 9'd0 || vdump != 9'd0) begin
            $display("timeout: no frame start seen");
            hung = 1'b1;
        end
        ticks = 0;
        guard = 0;
        while (ticks < FRAME_TICKS && guard < WAIT_LIMIT && !hung) begin
            @(negedge clk);
            guard++;
            // pxl_cen still holds the value of the edge just passed
            if (pxl_cen) begin
                // rgb lags the counters by one tick
                h      = ticks % H_TOTAL;
                v      = ticks / H_TOTAL;
                h_next = (ticks + 1) % H_TOTAL;
                v_next = ((ticks + 1) / H_TOTAL) % V_TOTAL;
                hs_exp = h_next >= HS_FIRST && h_next <= HS_LAST;
                vs_exp = v_next == VS_LINE;
                compare($sformatf("raster at tick %0d", ticks + 1),
                        {12'd0, hdump, vdump, hs, vs},
                        {12'd0, 9'(h_next), 9'(v_next), hs_exp, vs_exp});
                if (check_en) begin
                    compare($sformatf("pixel h %0d v %0d", h, v),
                            {6'd0, hb_dly, vb_dly, red, green, blue},
                            {6'd0, expected_video(h, v)});
                end
                ticks++;
            end
        end
        if (ticks < FRAME_TICKS && !hung) begin
            $display("timeout: pixel enable stopped in the middle of a frame");
            hung = 1'b1;
        end
    endtask

    initial begin
        int a;
        int r;
        int f;
        int row_start;
        rst_n    = 1'b0;
        cpu_cs   = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_din  = '0;
        for (a = 0; a < 65536; a++) begin
            vram_m[a] = 16'($random(seed));
        end
        for (a = 0; a < 16; a++) begin
            pal_m[a] = pal_entry_t'(12'($random(seed)));
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (a = 0; a < 16; a++) begin
            write_reg(PAL_BASE + 5'(a), {4'h0, pal_m[a]});
        end

        for (r = 0; r < ROWS && !hung; r++) begin
            row_start = errors;
            await_vblank();
            ctrl_m    = 16'(stim[r][0]);
            base_m    = 16'(stim[r][1]);
            hscroll_m = 16'(stim[r][2]);
            vscroll_m = 16'(stim[r][3]);
            vram_mode = stim[r][4];
            write_reg(REG_CTRL, ctrl_m);
            write_reg(REG_BASE, base_m);
            write_reg(REG_HSCROLL, hscroll_m);
            write_reg(REG_VSCROLL, vscroll_m);
            read_expect(REG_CTRL, ctrl_m, "ctrl readback");
            read_expect(REG_BASE, base_m, "base readback");
            read_expect(REG_HSCROLL, hscroll_m, "hscroll readback");
            read_expect(REG_VSCROLL, vscroll_m, "vscroll readback");
            read_expect(PAL_BASE + 5'(r), 16'd0, "palette readback");
            if (vram_mode == 2) begin
                for (f = 0; f < stim[r][5]; f++) begin
                    scan_frame(1'b0);
                end
                read_expect(REG_STATUS, 16'd1, "underrun flag set");
            end else begin
                for (f = 0; f < stim[r][5]; f++) begin
                    scan_frame(1'b1);
                    // earlier slow rows leave the flag set
                    if (f == 0) begin
                        write_reg(REG_STATUS, 16'h0001);
                        read_expect(REG_STATUS, 16'd0, "underrun flag cleared");
                    end
                end
                read_expect(REG_STATUS, 16'd0, "underrun flag stays clear");
            end
            $display("row %0d ctrl %h base %h hscroll %0d vscroll %0d mode %0d: %0d errors",
                     r, ctrl_m, base_m, hscroll_m, vscroll_m, vram_mode, errors - row_start);
        end

        $display("%0d rows run, %0d checks, %0d errors", r, checks, errors);
        if (errors == 0 && !hung) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+tests
hdl/video_pkg.sv
hdl/video_regs_if.sv
hdl/video_timing.sv
hdl/video_mmr.sv
hdl/layer_fetch.sv
hdl/colmix.sv
hdl/video_top.sv
tests/video_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module video_tb -f list.f -o video_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/video_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0
